//--- Makefile
VERILATOR ?= verilator
TOP       ?= idu_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: run build lint clean

run: build
	./$(BUILD_DIR)/V$(TOP)

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- all.f
logic/idu_pkg.sv
logic/operand_if.sv
logic/inst_decoder.sv
logic/gpr_file.sv
logic/csr_file.sv
logic/decode_stage.sv
logic/idu_top.sv
verif/idu_tb.sv

//--- logic/csr_file.sv
module csr_file import idu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    operand_if.csr          ops,
    input  logic            csr_we,
    input  logic [11:0]     csr_waddr,
    input  logic [xlen-1:0] csr_wdata
);

    logic [xlen-1:0] mstatus;
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mcause;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (csr_we) begin
            case (csr_waddr)
                csr_mstatus: mstatus <= csr_wdata;
                csr_mtvec:   mtvec   <= csr_wdata;
                csr_mepc:    mepc    <= csr_wdata;
                csr_mcause:  mcause  <= csr_wdata;
                default: ; // id registers and unknown addresses drop the write.
            endcase
        end
    end

    always_comb begin
        case (ops.csr_addr)
            csr_mstatus:   ops.csr_data = mstatus;
            csr_mtvec:     ops.csr_data = mtvec;
            csr_mepc:      ops.csr_data = mepc;
            csr_mcause:    ops.csr_data = mcause;
            csr_mvendorid: ops.csr_data = mvendorid_value;
            csr_marchid:   ops.csr_data = marchid_value;
            default:       ops.csr_data = '0;
        endcase
    end

endmodule

//--- logic/decode_stage.sv
module decode_stage import idu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            fetch_valid,
    input  logic [xlen-1:0] fetch_pc,
    input  logic [xlen-1:0] fetch_inst,
    input  logic            exu_ready,
    input  logic            redirect,
    operand_if.stage        ops,
    output logic            decode_ready,
    output logic            dec_valid,
    output logic [xlen-1:0] dec_pc,
    output decode_t         dec_info,
    output logic [xlen-1:0] dec_src1,
    output logic [xlen-1:0] dec_src2,
    output logic [xlen-1:0] dec_csr_data
);

    decode_t info;

    inst_decoder u_decoder (
        .inst (fetch_inst),
        .info (info)
    );

    assign ops.rs1_addr = info.rs1;
    assign ops.rs2_addr = info.rs2;
    assign ops.csr_addr = info.imm[11:0]; // csr number sits in the I immediate.

    // the stage holds no buffer of its own, so it is ready whenever execute is.
    assign decode_ready = exu_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_valid    <= 1'b0;
            dec_pc       <= '0;
            dec_info     <= '0;
            dec_src1     <= '0;
            dec_src2     <= '0;
            dec_csr_data <= '0;
        end else if (exu_ready) begin
            if (fetch_valid) begin
                dec_valid    <= ~redirect; // a redirect squashes the word being taken.
                dec_pc       <= fetch_pc;
                dec_info     <= info;
                dec_src1     <= ops.src1;
                dec_src2     <= ops.src2;
                dec_csr_data <= ops.csr_data;
            end else begin
                dec_valid    <= 1'b0;
                dec_pc       <= '0;
                dec_info     <= '0;
                dec_src1     <= '0;
                dec_src2     <= '0;
                dec_csr_data <= '0;
            end
        end
    end

endmodule

//--- logic/gpr_file.sv
module gpr_file import idu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    operand_if.gpr          ops,
    input  logic            gpr_we,
    input  logic [4:0]      gpr_waddr,
    input  logic [xlen-1:0] gpr_wdata
);

    logic [xlen-1:0] regs [0:31];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (gpr_we && (gpr_waddr != 5'd0)) begin
            regs[gpr_waddr] <= gpr_wdata;
        end
    end

    // there is no bypass, so a write shows up on the read port one cycle later.
    assign ops.src1 = (ops.rs1_addr == 5'd0) ? '0 : regs[ops.rs1_addr];
    assign ops.src2 = (ops.rs2_addr == 5'd0) ? '0 : regs[ops.rs2_addr];

endmodule

//--- logic/idu_pkg.sv
package idu_pkg;

    localparam int xlen = 32;

    // machine CSR addresses.
    localparam logic [11:0] csr_mstatus   = 12'h300;
    localparam logic [11:0] csr_mtvec     = 12'h305;
    localparam logic [11:0] csr_mepc      = 12'h341;
    localparam logic [11:0] csr_mcause    = 12'h342;
    localparam logic [11:0] csr_mvendorid = 12'hF11;
    localparam logic [11:0] csr_marchid   = 12'hF12;

    localparam logic [xlen-1:0] mvendorid_value = 32'h7973_7978;
    localparam logic [xlen-1:0] marchid_value   = 32'h0000_0025;

    localparam logic [6:0] op_load   = 7'h03;
    localparam logic [6:0] op_imm    = 7'h13;
    localparam logic [6:0] op_store  = 7'h23;
    localparam logic [6:0] op_branch = 7'h63;
    localparam logic [6:0] op_reg    = 7'h33;
    localparam logic [6:0] op_lui    = 7'h37;
    localparam logic [6:0] op_auipc  = 7'h17;
    localparam logic [6:0] op_jal    = 7'h6f;
    localparam logic [6:0] op_jalr   = 7'h67;
    localparam logic [6:0] op_system = 7'h73;
    localparam logic [6:0] op_fence  = 7'h0f;

    // bit positions inside the one-hot alu_op field.
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_or   = 5;
    localparam int alu_xor  = 6;
    localparam int alu_sll  = 7;
    localparam int alu_srl  = 8;
    localparam int alu_sra  = 9;
    localparam int alu_lui  = 10;
    localparam int alu_bne  = 11;
    localparam int alu_beq  = 12;
    localparam int alu_bge  = 13;
    localparam int alu_bgeu = 14;
    localparam int alu_blt  = 15;
    localparam int alu_bltu = 16;

    localparam int alu_op_w = 17;

    typedef struct packed {
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [4:0]          rd;
        logic [xlen-1:0]     imm;
        logic [alu_op_w-1:0] alu_op;
        logic                gpr_we;
        logic                load;
        logic                store;
        logic                src1_is_pc;
        logic                src2_is_imm;
        logic                is_jump;
        logic                is_branch;
        logic                csr_rw;
        logic                csr_rs;
        logic                ecall;
        logic                mret;
        logic                ebreak;
        logic                fence_i;
        logic                illegal;
        logic [2:0]          load_size;  // {word, half, byte}.
        logic [2:0]          store_size; // {word, half, byte}.
        logic                load_unsigned;
    } decode_t;

endpackage

//--- logic/idu_top.sv
module idu_top import idu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            fetch_valid,
    input  logic [xlen-1:0] fetch_pc,
    input  logic [xlen-1:0] fetch_inst,
    input  logic            exu_ready,
    input  logic            redirect,
    input  logic            gpr_we,
    input  logic [4:0]      gpr_waddr,
    input  logic [xlen-1:0] gpr_wdata,
    input  logic            csr_we,
    input  logic [11:0]     csr_waddr,
    input  logic [xlen-1:0] csr_wdata,
    output logic            decode_ready,
    output logic            dec_valid,
    output logic [xlen-1:0] dec_pc,
    output decode_t         dec_info,
    output logic [xlen-1:0] dec_src1,
    output logic [xlen-1:0] dec_src2,
    output logic [xlen-1:0] dec_csr_data
);

    operand_if ops ();

    decode_stage u_stage (
        .clk          (clk),
        .rst          (rst),
        .fetch_valid  (fetch_valid),
        .fetch_pc     (fetch_pc),
        .fetch_inst   (fetch_inst),
        .exu_ready    (exu_ready),
        .redirect     (redirect),
        .ops          (ops.stage),
        .decode_ready (decode_ready),
        .dec_valid    (dec_valid),
        .dec_pc       (dec_pc),
        .dec_info     (dec_info),
        .dec_src1     (dec_src1),
        .dec_src2     (dec_src2),
        .dec_csr_data (dec_csr_data)
    );

    gpr_file u_gpr (
        .clk       (clk),
        .rst       (rst),
        .ops       (ops.gpr),
        .gpr_we    (gpr_we),
        .gpr_waddr (gpr_waddr),
        .gpr_wdata (gpr_wdata)
    );

    csr_file u_csr (
        .clk       (clk),
        .rst       (rst),
        .ops       (ops.csr),
        .csr_we    (csr_we),
        .csr_waddr (csr_waddr),
        .csr_wdata (csr_wdata)
    );

endmodule

//--- logic/inst_decoder.sv
module inst_decoder import idu_pkg::*; (
    input  logic [xlen-1:0] inst,
    output decode_t         info
);

    wire [6:0] opcode = inst[6:0];
    wire [2:0] f3     = inst[14:12];
    wire [6:0] f7     = inst[31:25];
    wire [4:0] rd     = inst[11:7];
    wire [4:0] rs1    = inst[19:15];
    wire [4:0] rs2    = inst[24:20];

    wire r_op   = (opcode == op_reg);
    wire i_op   = (opcode == op_imm);
    wire ld_op  = (opcode == op_load);
    wire st_op  = (opcode == op_store);
    wire br_op  = (opcode == op_branch);
    wire sys_op = (opcode == op_system);

    wire inst_add  = r_op & (f3 == 3'h0) & (f7 == 7'h00);
    wire inst_sub  = r_op & (f3 == 3'h0) & (f7 == 7'h20);
    wire inst_sll  = r_op & (f3 == 3'h1) & (f7 == 7'h00);
    wire inst_slt  = r_op & (f3 == 3'h2) & (f7 == 7'h00);
    wire inst_sltu = r_op & (f3 == 3'h3) & (f7 == 7'h00);
    wire inst_xor  = r_op & (f3 == 3'h4) & (f7 == 7'h00);
    wire inst_srl  = r_op & (f3 == 3'h5) & (f7 == 7'h00);
    wire inst_sra  = r_op & (f3 == 3'h5) & (f7 == 7'h20);
    wire inst_or   = r_op & (f3 == 3'h6) & (f7 == 7'h00);
    wire inst_and  = r_op & (f3 == 3'h7) & (f7 == 7'h00);

    wire inst_addi  = i_op & (f3 == 3'h0);
    wire inst_slli  = i_op & (f3 == 3'h1) & (f7 == 7'h00);
    wire inst_sltiu = i_op & (f3 == 3'h3);
    wire inst_xori  = i_op & (f3 == 3'h4);
    wire inst_srli  = i_op & (f3 == 3'h5) & (f7 == 7'h00);
    wire inst_srai  = i_op & (f3 == 3'h5) & (f7 == 7'h20);
    wire inst_ori   = i_op & (f3 == 3'h6);
    wire inst_andi  = i_op & (f3 == 3'h7);

    wire inst_lb  = ld_op & (f3 == 3'h0);
    wire inst_lh  = ld_op & (f3 == 3'h1);
    wire inst_lw  = ld_op & (f3 == 3'h2);
    wire inst_lbu = ld_op & (f3 == 3'h4);
    wire inst_lhu = ld_op & (f3 == 3'h5);
    wire inst_sb  = st_op & (f3 == 3'h0);
    wire inst_sh  = st_op & (f3 == 3'h1);
    wire inst_sw  = st_op & (f3 == 3'h2);

    wire inst_beq  = br_op & (f3 == 3'h0);
    wire inst_bne  = br_op & (f3 == 3'h1);
    wire inst_blt  = br_op & (f3 == 3'h4);
    wire inst_bge  = br_op & (f3 == 3'h5);
    wire inst_bltu = br_op & (f3 == 3'h6);
    wire inst_bgeu = br_op & (f3 == 3'h7);

    wire inst_lui   = (opcode == op_lui);
    wire inst_auipc = (opcode == op_auipc);
    wire inst_jal   = (opcode == op_jal);
    wire inst_jalr  = (opcode == op_jalr) & (f3 == 3'h0);
    wire inst_csrrw = sys_op & (f3 == 3'h1);
    wire inst_csrrs = sys_op & (f3 == 3'h2);

    // privileged words share opcode with zero funct3, rd and rs1.
    wire sys_plain   = sys_op & (f3 == 3'h0) & (rd == 5'd0) & (rs1 == 5'd0);
    wire inst_ecall  = sys_plain & (f7 == 7'h00) & (rs2 == 5'd0);
    wire inst_ebreak = sys_plain & (f7 == 7'h00) & (rs2 == 5'd1);
    wire inst_mret   = sys_plain & (f7 == 7'h18) & (rs2 == 5'd2);
    wire inst_fence_i = (opcode == op_fence) & (f3 == 3'h1) & (rd == 5'd0) &
                        (rs1 == 5'd0) & (rs2 == 5'd0) & (f7 == 7'h00);
    wire inst_wait    = (inst == '0); // all-zero word idles the core.

    wire is_load  = inst_lb | inst_lh | inst_lw | inst_lbu | inst_lhu;
    wire is_store = inst_sb | inst_sh | inst_sw;

    wire type_r = inst_add | inst_sub | inst_sll | inst_slt | inst_sltu |
                  inst_xor | inst_srl | inst_sra | inst_or | inst_and;
    wire type_i = inst_addi | inst_slli | inst_sltiu | inst_xori | inst_srli |
                  inst_srai | inst_ori | inst_andi | is_load | inst_jalr |
                  inst_csrrw | inst_csrrs | inst_fence_i;
    wire type_b = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;
    wire type_u = inst_lui | inst_auipc;
    wire type_n = inst_ecall | inst_ebreak | inst_mret | inst_wait;

    wire [xlen-1:0] imm_i = {{20{inst[31]}}, inst[31:20]};
    wire [xlen-1:0] imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    wire [xlen-1:0] imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    wire [xlen-1:0] imm_u = {inst[31:12], 12'b0};
    wire [xlen-1:0] imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        info     = '0;
        info.rs1 = rs1;
        info.rs2 = rs2;
        info.rd  = rd;

        if (type_i) info.imm = imm_i;
        else if (is_store) info.imm = imm_s;
        else if (type_b) info.imm = imm_b;
        else if (type_u) info.imm = imm_u;
        else if (inst_jal) info.imm = imm_j;

        // address arithmetic for memory, jumps and auipc goes through add.
        info.alu_op[alu_add]  = inst_add | inst_addi | inst_auipc | inst_jal |
                                inst_jalr | is_load | is_store;
        info.alu_op[alu_sub]  = inst_sub;
        info.alu_op[alu_slt]  = inst_slt;
        info.alu_op[alu_sltu] = inst_sltu | inst_sltiu;
        info.alu_op[alu_and]  = inst_and | inst_andi;
        info.alu_op[alu_or]   = inst_or | inst_ori;
        info.alu_op[alu_xor]  = inst_xor | inst_xori;
        info.alu_op[alu_sll]  = inst_sll | inst_slli;
        info.alu_op[alu_srl]  = inst_srl | inst_srli;
        info.alu_op[alu_sra]  = inst_sra | inst_srai;
        info.alu_op[alu_lui]  = inst_lui;
        info.alu_op[alu_bne]  = inst_bne;
        info.alu_op[alu_beq]  = inst_beq;
        info.alu_op[alu_bge]  = inst_bge;
        info.alu_op[alu_bgeu] = inst_bgeu;
        info.alu_op[alu_blt]  = inst_blt;
        info.alu_op[alu_bltu] = inst_bltu;

        info.gpr_we = type_r | (type_i & ~inst_fence_i) | inst_jal | type_u;
        info.load   = is_load;
        info.store  = is_store;

        info.src1_is_pc  = inst_jal | inst_auipc | type_b;
        info.src2_is_imm = type_i | is_store | type_u | inst_jal | type_b;
        info.is_jump     = inst_jal | inst_jalr | type_b | inst_ecall | inst_mret;
        info.is_branch   = type_b;

        info.csr_rw  = inst_csrrw;
        info.csr_rs  = inst_csrrs;
        info.ecall   = inst_ecall;
        info.mret    = inst_mret;
        info.ebreak  = inst_ebreak;
        info.fence_i = inst_fence_i;
        info.illegal = ~(type_r | type_i | is_store | type_b | type_u | inst_jal | type_n);

        info.load_size     = {inst_lw, inst_lh | inst_lhu, inst_lb | inst_lbu};
        info.store_size    = {inst_sw, inst_sh, inst_sb};
        info.load_unsigned = inst_lbu | inst_lhu;
    end

endmodule

//--- logic/operand_if.sv
interface operand_if import idu_pkg::*; ();

    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [11:0]     csr_addr;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] csr_data;

    // reads are combinational and the data comes back in the same cycle.
    modport stage (output rs1_addr, output rs2_addr, output csr_addr,
                   input src1, input src2, input csr_data);

    modport gpr (input rs1_addr, input rs2_addr, output src1, output src2);

    modport csr (input csr_addr, output csr_data);

endinterface

//--- verif/idu_input.txt
// cmd: 1 gpr write, 2 csr write (addr data), 3 issue (pc inst redirect stall), 4 idle
// then: exp_pc rd imm alu_op flags src1 src2 csr_data valid (unused words are 0)
1 1 12345678 0 0 0 0 0 0 0 0 0 0 0
1 2 4 0 0 0 0 0 0 0 0 0 0 0
1 0 DEADBEEF 0 0 0 0 0 0 0 0 0 0 0
3 100 002081B3 0 0 100 3 0 1 100000 12345678 4 0 1
3 104 40208233 0 0 104 4 0 2 100000 12345678 4 0 1
3 108 4000D2B3 0 0 108 5 0 200 100000 12345678 0 0 1
3 10C 4030D313 0 0 10C 6 403 200 110000 12345678 0 0 1
3 110 FFF13393 0 0 110 7 FFFFFFFF 8 110000 4 0 0 1
3 114 7F00C413 0 0 114 8 7F0 40 110000 12345678 0 0 1
3 118 0040A783 0 3 118 F 4 1 190040 12345678 0 0 1
3 11C FE20AC23 0 0 11C 18 FFFFFFF8 1 50008 12345678 4 0 1
3 120 FE2088E3 0 0 120 11 FFFFFFF0 1000 3C000 12345678 4 0 1
3 124 ABCDE4B7 0 0 124 9 ABCDE000 400 110000 0 0 0 1
3 128 12345517 0 0 128 A 12345000 1 130000 0 0 0 1
3 12C FFDFF0EF 0 0 12C 1 FFFFFFFC 1 138000 0 0 0 1
3 130 00C08067 0 0 130 0 C 1 118000 12345678 0 0 1
2 305 80000100 0 0 0 0 0 0 0 0 0 0 0
2 341 444 0 0 0 0 0 0 0 0 0 0 0
2 F11 FFFFFFFF 0 0 0 0 0 0 0 0 0 0 0
3 134 305115F3 0 0 134 B 305 0 112000 4 0 80000100 1
3 138 34102673 0 0 138 C 341 0 111000 0 12345678 444 1
3 13C F11026F3 0 0 13C D FFFFFF11 0 111000 0 0 79737978 1
3 140 7C002773 0 0 140 E 7C0 0 111000 0 0 0 1
3 144 00000073 0 0 144 0 0 0 8800 0 0 0 1
3 148 30200073 0 0 148 0 0 0 8400 0 4 0 1
3 14C 00100073 0 0 14C 0 0 0 200 0 12345678 0 1
3 150 0000100F 0 0 150 0 0 0 10100 0 0 0 1
3 154 00000000 0 0 154 0 0 0 0 0 0 0 1
3 158 0000058B 0 0 158 B 0 0 80 0 0 0 1
4 0 0 0 0 0 0 0 0 0 0 0 0 0
3 15C 002081B3 1 0 15C 3 0 1 100000 12345678 4 0 0

//--- verif/idu_tb.sv
module idu_tb import idu_pkg::*; ();

    localparam int rec_words     = 14;
    localparam int rec_max       = 64;
    localparam int ready_timeout = 50;
    localparam int run_limit     = 20000;

    logic            clk = 1'b0;
    logic            rst;
    logic            fetch_valid;
    logic [31:0]     fetch_pc;
    logic [31:0]     fetch_inst;
    logic            exu_ready;
    logic            redirect;
    logic            gpr_we;
    logic [4:0]      gpr_waddr;
    logic [31:0]     gpr_wdata;
    logic            csr_we;
    logic [11:0]     csr_waddr;
    logic [31:0]     csr_wdata;
    logic            decode_ready;
    logic            dec_valid;
    logic [31:0]     dec_pc;
    decode_t         dec_info;
    logic [31:0]     dec_src1;
    logic [31:0]     dec_src2;
    logic [31:0]     dec_csr_data;

    logic [31:0] stim [0:rec_words*rec_max-1];
    int          issued = 0;

    idu_top DUT (
        .clk          (clk),
        .rst          (rst),
        .fetch_valid  (fetch_valid),
        .fetch_pc     (fetch_pc),
        .fetch_inst   (fetch_inst),
        .exu_ready    (exu_ready),
        .redirect     (redirect),
        .gpr_we       (gpr_we),
        .gpr_waddr    (gpr_waddr),
        .gpr_wdata    (gpr_wdata),
        .csr_we       (csr_we),
        .csr_waddr    (csr_waddr),
        .csr_wdata    (csr_wdata),
        .decode_ready (decode_ready),
        .dec_valid    (dec_valid),
        .dec_pc       (dec_pc),
        .dec_info     (dec_info),
        .dec_src1     (dec_src1),
        .dec_src2     (dec_src2),
        .dec_csr_data (dec_csr_data)
    );

    always #2 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "testbench stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            stop_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // the flag word packs gpr_we into bit 20 and continues down to load_unsigned in bit 0.
    function automatic logic [20:0] pack_flags(input decode_t d);
        return {d.gpr_we, d.load, d.store, d.src1_is_pc, d.src2_is_imm, d.is_jump,
                d.is_branch, d.csr_rw, d.csr_rs, d.ecall, d.mret, d.ebreak, d.fence_i,
                d.illegal, d.load_size, d.store_size, d.load_unsigned};
    endfunction

    task automatic write_gpr(input int b);
        gpr_we    = 1'b1;
        gpr_waddr = stim[b+1][4:0];
        gpr_wdata = stim[b+2];
        @(negedge clk);
        gpr_we    = 1'b0;
    endtask

    task automatic write_csr(input int b);
        csr_we    = 1'b1;
        csr_waddr = stim[b+1][11:0];
        csr_wdata = stim[b+2];
        @(negedge clk);
        csr_we    = 1'b0;
    endtask

    task automatic issue(input int b);
        int          stall;
        int          tries;
        int          i;
        logic        hold_valid;
        logic [31:0] hold_pc;
        logic [31:0] hold_src1;
        logic [31:0] hold_src2;
        logic [31:0] hold_csr;
        decode_t     hold_info;
        stall      = int'(stim[b+4]);
        hold_valid = dec_valid;
        hold_pc    = dec_pc;
        hold_src1  = dec_src1;
        hold_src2  = dec_src2;
        hold_csr   = dec_csr_data;
        hold_info  = dec_info;
        fetch_valid = 1'b1;
        fetch_pc    = stim[b+1];
        fetch_inst  = stim[b+2];
        redirect    = stim[b+3][0];
        exu_ready   = (stall == 0);
        for (i = 0; i < stall; i++) begin
            @(negedge clk); // execute is stalled and nothing may move.
            check_value("decode_ready", {31'b0, decode_ready}, 32'd0);
            check_value("dec_valid", {31'b0, dec_valid}, {31'b0, hold_valid});
            check_value("dec_pc", dec_pc, hold_pc);
            check_value("dec_src1", dec_src1, hold_src1);
            check_value("dec_src2", dec_src2, hold_src2);
            check_value("dec_csr_data", dec_csr_data, hold_csr);
            assert (dec_info === hold_info) else begin
                stop_run($sformatf("FAILED dec_info: got 0x%h, expected 0x%h",
                                   dec_info, hold_info));
            end
        end
        exu_ready = 1'b1;
        tries     = 0;
        do begin
            @(posedge clk);
            tries++;
            if (tries > ready_timeout) stop_run("decode_ready never rose to take the fetch");
        end while (decode_ready !== 1'b1);
        @(negedge clk); // one cycle after the accepting edge.
        check_value("dec_valid", {31'b0, dec_valid}, stim[b+13]);
        check_value("dec_pc", dec_pc, stim[b+5]);
        check_value("dec_info.rd", {27'b0, dec_info.rd}, stim[b+6]);
        // rs1 and rs2 sit at their fixed RV32I positions in every format.
        check_value("dec_info.rs1", {27'b0, dec_info.rs1}, {27'b0, stim[b+2][19:15]});
        check_value("dec_info.rs2", {27'b0, dec_info.rs2}, {27'b0, stim[b+2][24:20]});
        check_value("dec_info.imm", dec_info.imm, stim[b+7]);
        check_value("dec_info.alu_op", {15'b0, dec_info.alu_op}, stim[b+8]);
        check_value("dec_info flags", {11'b0, pack_flags(dec_info)}, stim[b+9]);
        check_value("dec_src1", dec_src1, stim[b+10]);
        check_value("dec_src2", dec_src2, stim[b+11]);
        check_value("dec_csr_data", dec_csr_data, stim[b+12]);
        fetch_valid = 1'b0;
        redirect    = 1'b0;
        issued++;
    endtask

    task automatic idle_cycle(input int b);
        fetch_valid = 1'b0;
        exu_ready   = 1'b1;
        @(negedge clk);
        check_value("dec_valid", {31'b0, dec_valid}, stim[b+13]);
        check_value("dec_pc", dec_pc, stim[b+5]);
        check_value("dec_src1", dec_src1, stim[b+10]);
        check_value("dec_src2", dec_src2, stim[b+11]);
        check_value("dec_csr_data", dec_csr_data, stim[b+12]);
        assert (dec_info === '0) else begin
            stop_run($sformatf("FAILED dec_info: got 0x%h, expected 0x0", dec_info));
        end
    endtask

    task automatic load_stimulus();
        int fd;
        fd = $fopen("verif/idu_input.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open the stimulus file verif/idu_input.txt");
        end else begin
            $fclose(fd);
            $readmemh("verif/idu_input.txt", stim);
        end
    endtask

    initial begin
        #(run_limit);
        stop_run("the run went past its time limit without finishing");
    end

    initial begin
        int rec;
        rst         = 1'b1;
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        fetch_inst  = '0;
        exu_ready   = 1'b0;
        redirect    = 1'b0;
        gpr_we      = 1'b0;
        gpr_waddr   = '0;
        gpr_wdata   = '0;
        csr_we      = 1'b0;
        csr_waddr   = '0;
        csr_wdata   = '0;
        load_stimulus();
        repeat (4) @(negedge clk);
        check_value("dec_valid", {31'b0, dec_valid}, 32'd0);
        check_value("dec_pc", dec_pc, 32'd0);
        rst       = 1'b0;
        exu_ready = 1'b1;
        @(negedge clk);
        rec = 0;
        while (rec < rec_max &&
               stim[rec*rec_words] inside {32'd1, 32'd2, 32'd3, 32'd4}) begin
            case (stim[rec*rec_words])
                32'd1:   write_gpr(rec * rec_words);
                32'd2:   write_csr(rec * rec_words);
                32'd3:   issue(rec * rec_words);
                default: idle_cycle(rec * rec_words);
            endcase
            rec++;
        end
        if (issued == 0) begin
            stop_run("the stimulus file held no issue commands");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule
